// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/100ps
TOP      = tb_bnn_ctrl
FILELIST = project.f
OBJ_DIR  = obj_dir
SIM      = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the run printed the pass line
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "^Test OK$$"

clean:
	rm -rf $(OBJ_DIR)

// File: hw/bnn_ctrl_pkg.sv
package bnn_ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // sizes

    localparam int LANES      = 4;      // lanes per beat, also units per group
    localparam int NUM_GROUPS = 4;
    localparam int UNITS      = LANES * NUM_GROUPS;
    localparam int SEL_W      = 4;      // wide enough for all 16 units
    localparam int WGT_W      = 7;
    localparam int PIX_W      = 10;
    localparam int BYTE_W     = 8;
    localparam int BIAS_BYTES = 8;

    ////////////////////////////////////////////////////////////
    // instruction and data beat

    // declared msb first, bias_wr ends up at bit 11 and psum_rst at bit 0
    typedef struct packed {
        logic             bias_wr;
        logic             bin_wr;
        logic             group_add;      // accumulate across units
        logic             img_en;
        logic             wgt_en;
        logic             img_data_sel;
        logic             psum_add;
        logic [SEL_W-1:0] sel;            // group on loads, unit/group on compute
        logic             psum_rst;
    } instr_t;

    typedef struct packed {
        logic [LANES-1:0][BYTE_W-1:0] lane;
    } data_beat_t;

    typedef enum logic [2:0] {
        OP_IDLE,
        OP_PSUM_RST,
        OP_PSUM_ADD,
        OP_GROUP_ADD,
        OP_BIN_WR
    } calc_op_t;

    typedef enum logic [1:0] {
        PH_WGT,
        PH_BIAS,
        PH_DONE
    } load_phase_t;

    ////////////////////////////////////////////////////////////
    // fill rules

    // weight word of one unit at one address
    function automatic logic [WGT_W-1:0] wgt_word(
        input int unsigned unit_idx,
        input int unsigned addr
    );
        return WGT_W'((unit_idx * 29 + addr * 13 + 7) % (2 ** WGT_W));
    endfunction

    function automatic logic [BYTE_W-1:0] bias_byte(
        input int unsigned index
    );
        return BYTE_W'((index * 53 + 41) % (2 ** BYTE_W));
    endfunction

    // raw pixel, full width before the row shift
    function automatic logic [PIX_W-1:0] pixel_word(
        input int unsigned unit_idx,
        input int unsigned col
    );
        return PIX_W'((unit_idx * 97 + col * 61 + 3) % (2 ** PIX_W));
    endfunction

endpackage

// File: hw/bnn_ctrl_top.sv
`timescale 1ns/100ps

module bnn_ctrl_top #(
    parameter int WGT_DEPTH   = 56,
    parameter int IMG_COLS    = 10,
    parameter int WINDOW_COLS = 6,
    parameter int KERNEL_TAPS = 6
) (
    input  logic                     clk,
    input  logic                     rst,
    output bnn_ctrl_pkg::instr_t     instr,
    output bnn_ctrl_pkg::data_beat_t data
);

    bnn_ctrl_pkg::instr_t     ld_instr;
    bnn_ctrl_pkg::instr_t     st_instr;
    bnn_ctrl_pkg::instr_t     cs_instr;
    bnn_ctrl_pkg::data_beat_t ld_data;
    bnn_ctrl_pkg::data_beat_t st_data;
    logic                     load_done;
    logic                     calc_start;
    logic                     calc_done;

    ////////////////////////////////////////////////////////////
    // engines

    param_loader #(
        .WGT_DEPTH (WGT_DEPTH)
    ) loader_i (
        .clk       (clk),
        .rst       (rst),
        .ld_instr  (ld_instr),
        .ld_data   (ld_data),
        .load_done (load_done)
    );

    img_streamer #(
        .IMG_COLS    (IMG_COLS),
        .WINDOW_COLS (WINDOW_COLS)
    ) streamer_i (
        .clk        (clk),
        .rst        (rst),
        .load_done  (load_done),
        .calc_done  (calc_done),
        .st_instr   (st_instr),
        .st_data    (st_data),
        .calc_start (calc_start)
    );

    calc_sequencer #(
        .KERNEL_TAPS (KERNEL_TAPS)
    ) seq_i (
        .clk        (clk),
        .rst        (rst),
        .calc_start (calc_start),
        .cs_instr   (cs_instr),
        .calc_done  (calc_done)
    );

    // one engine at a time, idle ones drive zeros
    assign instr = bnn_ctrl_pkg::instr_t'(ld_instr | st_instr | cs_instr);
    assign data  = bnn_ctrl_pkg::data_beat_t'(ld_data | st_data);   // sequencer has no data

endmodule

// File: hw/calc_sequencer.sv
`timescale 1ns/100ps

module calc_sequencer #(
    parameter int KERNEL_TAPS = 6
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 calc_start,
    output bnn_ctrl_pkg::instr_t cs_instr,
    output logic                 calc_done
);

    bnn_ctrl_pkg::calc_op_t          op;
    logic [bnn_ctrl_pkg::SEL_W-1:0] step;        // tap or unit index
    logic                            pass;        // image data select of this pass
    logic                            step_last;
    logic                            busy;

    assign busy = (op != bnn_ctrl_pkg::OP_IDLE);

    always_comb begin
        step_last = 1'b1;    // single cycle ops
        case (op)
            bnn_ctrl_pkg::OP_PSUM_ADD:
                step_last = (step == bnn_ctrl_pkg::SEL_W'(KERNEL_TAPS - 1));
            bnn_ctrl_pkg::OP_GROUP_ADD:
                step_last = (step == bnn_ctrl_pkg::SEL_W'(bnn_ctrl_pkg::UNITS - 1));
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // microsequence

    always_ff @(posedge clk) begin
        if (rst) begin
            op        <= bnn_ctrl_pkg::OP_IDLE;
            step      <= '0;
            pass      <= 1'b0;
            calc_done <= 1'b0;
        end else begin
            calc_done <= 1'b0;
            step      <= step_last ? '0 : step + 1'b1;
            case (op)
                bnn_ctrl_pkg::OP_IDLE: begin
                    if (calc_start) begin
                        op   <= bnn_ctrl_pkg::OP_PSUM_RST;
                        pass <= 1'b0;
                    end
                end
                bnn_ctrl_pkg::OP_PSUM_RST: begin
                    op <= bnn_ctrl_pkg::OP_PSUM_ADD;
                end
                bnn_ctrl_pkg::OP_PSUM_ADD: begin
                    if (step_last) begin
                        op <= bnn_ctrl_pkg::OP_GROUP_ADD;
                    end
                end
                bnn_ctrl_pkg::OP_GROUP_ADD: begin
                    if (step_last) begin
                        op <= bnn_ctrl_pkg::OP_BIN_WR;
                    end
                end
                bnn_ctrl_pkg::OP_BIN_WR: begin
                    if (pass) begin
                        op        <= bnn_ctrl_pkg::OP_IDLE;
                        calc_done <= 1'b1;
                    end else begin
                        op   <= bnn_ctrl_pkg::OP_PSUM_RST;     // second pass
                        pass <= 1'b1;
                    end
                end
                default: op <= bnn_ctrl_pkg::OP_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // opcode to instruction fields

    always_comb begin
        cs_instr              = '0;
        cs_instr.img_data_sel = pass;    // keeps last select between runs
        case (op)
            bnn_ctrl_pkg::OP_PSUM_RST: cs_instr.psum_rst = 1'b1;
            bnn_ctrl_pkg::OP_PSUM_ADD: begin
                cs_instr.psum_add = 1'b1;
                cs_instr.sel      = step;
            end
            bnn_ctrl_pkg::OP_GROUP_ADD: begin
                cs_instr.group_add = 1'b1;
                cs_instr.sel       = step;
            end
            bnn_ctrl_pkg::OP_BIN_WR:   cs_instr.bin_wr = 1'b1;
            default: ;
        endcase
    end

    // streamer has to hold off until calc_done
    a_start_when_idle: assert property (@(posedge clk) disable iff (rst)
        calc_start |-> !busy);

    a_one_op: assert property (@(posedge clk) disable iff (rst)
        $onehot0({cs_instr.psum_rst, cs_instr.psum_add, cs_instr.group_add, cs_instr.bin_wr}));

endmodule

// File: hw/img_streamer.sv
`timescale 1ns/100ps

module img_streamer #(
    parameter int IMG_COLS    = 10,
    parameter int WINDOW_COLS = 6
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     load_done,
    input  logic                     calc_done,
    output bnn_ctrl_pkg::instr_t     st_instr,
    output bnn_ctrl_pkg::data_beat_t st_data,
    output logic                     calc_start
);

    localparam int SLOT_CYCLES = 4;
    localparam int BEAT_SLOT   = 1;     // beat goes out in the second slot cycle
    localparam int SLOT_W      = $clog2(SLOT_CYCLES);
    localparam int GRP_W       = $clog2(bnn_ctrl_pkg::NUM_GROUPS);
    localparam int COL_W       = $clog2(IMG_COLS);

    logic [SLOT_W-1:0] slot;
    logic [GRP_W-1:0]  grp;
    logic [COL_W-1:0]  col;
    logic              row;
    logic              running;
    logic              waiting;     // compute run in flight
    logic              col_end;

    assign col_end = (slot == SLOT_W'(SLOT_CYCLES - 1)) &&
                     (grp == GRP_W'(bnn_ctrl_pkg::NUM_GROUPS - 1));

    ////////////////////////////////////////////////////////////
    // column walk

    always_ff @(posedge clk) begin
        if (rst) begin
            slot       <= '0;
            grp        <= '0;
            col        <= '0;
            row        <= 1'b0;
            running    <= 1'b0;
            waiting    <= 1'b0;
            calc_start <= 1'b0;
        end else begin
            calc_start <= 1'b0;
            if (!running) begin
                running <= load_done;
            end else if (waiting) begin
                if (calc_done) begin
                    waiting <= 1'b0;
                end
            end else begin
                slot <= slot + 1'b1;
                if (slot == SLOT_W'(SLOT_CYCLES - 1)) begin
                    grp <= grp + 1'b1;
                end
                if (col_end) begin
                    // window full from here on
                    if (col >= COL_W'(WINDOW_COLS - 1)) begin
                        calc_start <= 1'b1;
                        waiting    <= 1'b1;
                    end
                    if (col == COL_W'(IMG_COLS - 1)) begin
                        col <= '0;
                        row <= ~row;
                    end else begin
                        col <= col + 1'b1;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // image beats

    always_ff @(posedge clk) begin
        if (rst) begin
            st_instr <= '0;
            st_data  <= '0;
        end else begin
            st_instr <= '0;
            st_data  <= '0;
            if (running && !waiting && slot == SLOT_W'(BEAT_SLOT)) begin
                st_instr.img_en <= 1'b1;
                st_instr.sel    <= bnn_ctrl_pkg::SEL_W'(grp);
                for (int i = 0; i < bnn_ctrl_pkg::LANES; i++) begin
                    st_data.lane[i] <= bnn_ctrl_pkg::BYTE_W'(bnn_ctrl_pkg::pixel_word(
                        bnn_ctrl_pkg::LANES * int'(grp) + i, int'(col)) >> (2 * int'(row)));
                end
            end
        end
    end

    a_no_beat_in_calc: assert property (@(posedge clk) disable iff (rst)
        waiting |-> !st_instr.img_en);

endmodule

// File: hw/param_loader.sv
`timescale 1ns/100ps

module param_loader #(
    parameter int WGT_DEPTH = 56
) (
    input  logic                     clk,
    input  logic                     rst,
    output bnn_ctrl_pkg::instr_t     ld_instr,
    output bnn_ctrl_pkg::data_beat_t ld_data,
    output logic                     load_done
);

    localparam int WGT_SLOT    = WGT_DEPTH + 4;     // 4 idle cycles close each group
    localparam int BIAS_CYCLES = 14;
    localparam int BIAS_BEATS  = bnn_ctrl_pkg::BIAS_BYTES / bnn_ctrl_pkg::LANES;
    localparam int CNT_W       = $clog2(WGT_SLOT);
    localparam int GRP_W       = $clog2(bnn_ctrl_pkg::NUM_GROUPS);

    bnn_ctrl_pkg::load_phase_t phase;
    logic [GRP_W-1:0]          grp;
    logic [CNT_W-1:0]          cnt;         // position inside a weight slot or the bias phase
    logic                      done_seen;

    ////////////////////////////////////////////////////////////
    // phase sequencing

    always_ff @(posedge clk) begin
        if (rst) begin
            phase     <= bnn_ctrl_pkg::PH_WGT;
            grp       <= '0;
            cnt       <= '0;
            load_done <= 1'b0;
        end else begin
            load_done <= 1'b0;
            case (phase)
                bnn_ctrl_pkg::PH_WGT: begin
                    if (cnt == CNT_W'(WGT_SLOT - 1)) begin
                        cnt <= '0;
                        grp <= grp + 1'b1;
                        if (grp == GRP_W'(bnn_ctrl_pkg::NUM_GROUPS - 1)) begin
                            phase <= bnn_ctrl_pkg::PH_BIAS;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                bnn_ctrl_pkg::PH_BIAS: begin
                    if (cnt == CNT_W'(BIAS_CYCLES - 1)) begin
                        cnt       <= '0;
                        phase     <= bnn_ctrl_pkg::PH_DONE;
                        load_done <= 1'b1;   // lands in the last bias cycle
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: ;                   // parked until reset
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // beats

    always_ff @(posedge clk) begin
        if (rst) begin
            ld_instr <= '0;
            ld_data  <= '0;
        end else begin
            ld_instr <= '0;
            ld_data  <= '0;
            if (phase == bnn_ctrl_pkg::PH_WGT && cnt < CNT_W'(WGT_DEPTH)) begin
                ld_instr.wgt_en <= 1'b1;
                ld_instr.sel    <= bnn_ctrl_pkg::SEL_W'(grp);
                for (int i = 0; i < bnn_ctrl_pkg::LANES; i++) begin
                    // 7 bit word, zero extended
                    ld_data.lane[i] <= bnn_ctrl_pkg::BYTE_W'(bnn_ctrl_pkg::wgt_word(
                        bnn_ctrl_pkg::LANES * int'(grp) + i, int'(cnt)));
                end
            end else if (phase == bnn_ctrl_pkg::PH_BIAS && cnt < CNT_W'(BIAS_BEATS)) begin
                ld_instr.bias_wr <= 1'b1;
                for (int i = 0; i < bnn_ctrl_pkg::LANES; i++) begin
                    ld_data.lane[i] <= bnn_ctrl_pkg::bias_byte(
                        bnn_ctrl_pkg::LANES * int'(cnt) + i);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done_seen <= 1'b0;
        end else if (load_done) begin
            done_seen <= 1'b1;
        end
    end

    a_wgt_bias_excl: assert property (@(posedge clk) disable iff (rst)
        !(ld_instr.wgt_en && ld_instr.bias_wr));

    // streamer must get exactly one start
    a_done_once: assert property (@(posedge clk) disable iff (rst)
        load_done |-> !done_seen);

endmodule

// File: project.f
+incdir+sim
hw/bnn_ctrl_pkg.sv
hw/param_loader.sv
hw/img_streamer.sv
hw/calc_sequencer.sv
hw/bnn_ctrl_top.sv
sim/tb_bnn_ctrl.sv

// File: sim/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

////////////////////////////////////////////////////////////
// reference rules

function automatic logic [7:0] wgt_model(input int unit_idx, input int addr);
    return 8'((unit_idx * 29 + addr * 13 + 7) % 128);   // 7 bit word, zero extended
endfunction

function automatic logic [7:0] bias_model(input int index);
    return 8'((index * 53 + 41) % 256);
endfunction

// low byte of the pixel after the row shift
function automatic logic [7:0] pixel_model(input int unit_idx, input int col, input int row);
    return 8'(((unit_idx * 97 + col * 61 + 3) % 1024) >> (2 * row));
endfunction

// instruction at one step of a 24 cycle pass
function automatic bnn_ctrl_pkg::instr_t calc_model(input int step, input logic pass);
    bnn_ctrl_pkg::instr_t i;
    i              = '0;
    i.img_data_sel = pass;
    if (step == 0) begin
        i.psum_rst = 1'b1;
    end else if (step <= KERNEL_TAPS) begin
        i.psum_add = 1'b1;
        i.sel      = 4'(step - 1);                     // tap index
    end else if (step < PASS_CYCLES - 1) begin
        i.group_add = 1'b1;
        i.sel       = 4'(step - KERNEL_TAPS - 1);     // unit index
    end else begin
        i.bin_wr = 1'b1;
    end
    return i;
endfunction

////////////////////////////////////////////////////////////
// compare tasks

task automatic check_instr(input bnn_ctrl_pkg::instr_t got, input bnn_ctrl_pkg::instr_t exp,
                           input string what);
    if (got !== exp) begin
        fail_count++;
        $display("CHECK FAILED at %0t: %s: instr %h, expected %h", $time, what, got, exp);
        abort_run();
    end
endtask

task automatic check_data(input bnn_ctrl_pkg::data_beat_t got,
                          input bnn_ctrl_pkg::data_beat_t exp, input string what);
    if (got !== exp) begin
        fail_count++;
        $display("CHECK FAILED at %0t: %s: data %h, expected %h", $time, what, got, exp);
        abort_run();
    end
endtask

`endif

// File: sim/tb_bnn_ctrl.sv
`timescale 1ns/100ps

module tb_bnn_ctrl;

    localparam int WGT_DEPTH      = 56;
    localparam int IMG_COLS       = 10;
    localparam int WINDOW_COLS    = 6;
    localparam int KERNEL_TAPS    = 6;
    localparam int GROUPS         = 4;
    localparam int WGT_SLOT       = WGT_DEPTH + 4;
    localparam int BIAS_CYCLES    = 14;
    localparam int PASS_CYCLES    = KERNEL_TAPS + 18;    // rst, taps, 16 group adds, write
    localparam int RUN_CYCLES     = 2 * PASS_CYCLES;
    localparam int MAX_IDLE       = 3;                   // beats sit 4 cycles apart
    localparam int TIMEOUT_CYCLES = 3000;                // two loads, ~410 per row, margin

    logic                     clk = 1'b0;
    logic                     rst = 1'b1;
    bnn_ctrl_pkg::instr_t     instr;
    bnn_ctrl_pkg::data_beat_t data;
    logic                     data_sel_hold = 1'b0;      // select left behind by the last run
    int                       cycle_count   = 0;
    int                       fail_count    = 0;

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1, "run aborted");
    endtask

    `include "tb_checks.svh"

    bnn_ctrl_top #(
        .WGT_DEPTH   (WGT_DEPTH),
        .IMG_COLS    (IMG_COLS),
        .WINDOW_COLS (WINDOW_COLS),
        .KERNEL_TAPS (KERNEL_TAPS)
    ) dut_i (
        .clk   (clk),
        .rst   (rst),
        .instr (instr),
        .data  (data)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    ////////////////////////////////////////////////////////////
    // stepping

    task automatic sample(output bnn_ctrl_pkg::instr_t got_i,
                          output bnn_ctrl_pkg::data_beat_t got_d);
        @(posedge clk);
        got_i = instr;     // still the values registered at the previous edge
        got_d = data;
    endtask

    function automatic logic is_active(input bnn_ctrl_pkg::instr_t i);
        return i.psum_rst | i.psum_add | i.wgt_en | i.img_en | i.group_add | i.bin_wr
            | i.bias_wr;
    endfunction

    // idle cycles must be clean, then the next beat or opcode
    task automatic wait_active(output bnn_ctrl_pkg::instr_t got_i,
                               output bnn_ctrl_pkg::data_beat_t got_d);
        bnn_ctrl_pkg::instr_t idle_i;
        int                   idle;
        idle_i              = '0;
        idle_i.img_data_sel = data_sel_hold;
        idle                = 0;
        sample(got_i, got_d);
        while (!is_active(got_i) && idle < MAX_IDLE) begin
            check_instr(got_i, idle_i, "idle cycle");
            check_data(got_d, '0, "idle cycle");
            idle++;
            sample(got_i, got_d);
        end
        if (!is_active(got_i)) begin
            $display("no beat or opcode after %0d idle cycles", MAX_IDLE);
            abort_run();
        end
    endtask

    task automatic reset_dut();
        rst <= 1'b1;
        @(posedge clk);
        @(posedge clk);
        check_instr(instr, '0, "instr in reset");
        check_data(data, '0, "data in reset");
        rst <= 1'b0;
        @(posedge clk);
        check_instr(instr, '0, "instr after reset");
        check_data(data, '0, "data after reset");
        data_sel_hold = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests

    task automatic weight_phase();
        bnn_ctrl_pkg::instr_t     got_i;
        bnn_ctrl_pkg::instr_t     exp_i;
        bnn_ctrl_pkg::data_beat_t got_d;
        bnn_ctrl_pkg::data_beat_t exp_d;
        for (int g = 0; g < GROUPS; g++) begin
            for (int a = 0; a < WGT_SLOT; a++) begin
                sample(got_i, got_d);
                exp_i = '0;
                exp_d = '0;
                if (a < WGT_DEPTH) begin
                    exp_i.wgt_en = 1'b1;
                    exp_i.sel    = 4'(g);
                    for (int i = 0; i < 4; i++) begin
                        exp_d.lane[i] = wgt_model(4 * g + i, a);
                    end
                end
                check_instr(got_i, exp_i, $sformatf("weight instr g%0d a%0d", g, a));
                check_data(got_d, exp_d, $sformatf("weight data g%0d a%0d", g, a));
            end
        end
    endtask

    task automatic bias_phase();
        bnn_ctrl_pkg::instr_t     got_i;
        bnn_ctrl_pkg::instr_t     exp_i;
        bnn_ctrl_pkg::data_beat_t got_d;
        bnn_ctrl_pkg::data_beat_t exp_d;
        for (int k = 0; k < BIAS_CYCLES; k++) begin
            sample(got_i, got_d);
            exp_i = '0;
            exp_d = '0;
            if (k < 2) begin
                exp_i.bias_wr = 1'b1;
                for (int i = 0; i < 4; i++) begin
                    exp_d.lane[i] = bias_model(4 * k + i);
                end
            end
            check_instr(got_i, exp_i, $sformatf("bias instr cycle %0d", k));
            check_data(got_d, exp_d, $sformatf("bias data cycle %0d", k));
        end
    endtask

    // first opcode after the window fills, then back to back
    task automatic compute_run(input int len);
        bnn_ctrl_pkg::instr_t     got_i;
        bnn_ctrl_pkg::data_beat_t got_d;
        wait_active(got_i, got_d);
        for (int s = 0; s < len; s++) begin
            if (s > 0) begin
                sample(got_i, got_d);
            end
            check_instr(got_i, calc_model(s % PASS_CYCLES, s >= PASS_CYCLES),
                        $sformatf("run step %0d", s));
            check_data(got_d, '0, $sformatf("run step %0d", s));
        end
        if (len == RUN_CYCLES) begin
            data_sel_hold = 1'b1;
        end
    endtask

    // the run behind the last column is cut to last_run cycles
    task automatic image_row(input int row, input int num_cols, input int last_run);
        bnn_ctrl_pkg::instr_t     got_i;
        bnn_ctrl_pkg::instr_t     exp_i;
        bnn_ctrl_pkg::data_beat_t got_d;
        bnn_ctrl_pkg::data_beat_t exp_d;
        for (int c = 0; c < num_cols; c++) begin
            for (int g = 0; g < GROUPS; g++) begin
                wait_active(got_i, got_d);
                exp_i              = '0;
                exp_i.img_en       = 1'b1;
                exp_i.sel          = 4'(g);
                exp_i.img_data_sel = data_sel_hold;
                for (int i = 0; i < 4; i++) begin
                    exp_d.lane[i] = pixel_model(4 * g + i, c, row);
                end
                check_instr(got_i, exp_i, $sformatf("image instr r%0d c%0d g%0d", row, c, g));
                check_data(got_d, exp_d, $sformatf("image data r%0d c%0d g%0d", row, c, g));
            end
            if (c >= WINDOW_COLS - 1) begin
                compute_run((c == num_cols - 1) ? last_run : RUN_CYCLES);
            end
        end
    endtask

    task automatic reset_in_run();
        image_row(0, WINDOW_COLS, 10);    // stops inside the first run of the row
        reset_dut();
        weight_phase();
        bias_phase();
    endtask

    initial begin
        reset_dut();
        weight_phase();
        bias_phase();
        image_row(0, IMG_COLS, RUN_CYCLES);
        image_row(1, IMG_COLS, RUN_CYCLES);
        reset_in_run();
        if (fail_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule
